//--- design/mpuPkg.sv
package mpuPkg;

	localparam int dataWidth = 32;
	localparam int numLanes = 8;
	localparam int threadIdWidth = 4;
	localparam int numThreads = 1 << threadIdWidth;
	localparam int progDepth = 32;
	localparam int progIdxWidth = $clog2(progDepth);
	localparam int lengthWidth = progIdxWidth + 1; // a full program of progDepth words must fit.
	localparam int dataAddrWidth = 8;
	localparam int dataDepth = 1 << dataAddrWidth;
	localparam int hostFifoDepth = 4;
	localparam int readCreditWidth = 8;

	// command word bits, lowest set bit wins.
	localparam int cmdRun = 0;
	localparam int cmdStoreProg = 1;
	localparam int cmdStoreData = 2;
	localparam int cmdLoadData = 3;
	localparam int cmdStop = 4;
	localparam int cmdSetLanes = 5;

	typedef logic [dataWidth-1:0] word_t;

	typedef struct packed {
		logic valid;
		word_t data;
	} hostWord_t;

	typedef struct packed {
		logic write;
		logic [threadIdWidth-1:0] threadId;
		logic [progIdxWidth-1:0] index;
		word_t data;
	} progReq_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [dataAddrWidth-1:0] addr;
		word_t data;
	} dataReq_t;

	typedef struct packed {
		logic valid;
		logic [threadIdWidth-1:0] threadId;
		logic [lengthWidth-1:0] length;
		logic [numLanes-1:0] laneMask;
	} dispatch_t;

	typedef struct packed {
		logic noThread;
		logic stopped;
		logic running;
		logic ready;
	} status_t;

endpackage

//--- design/creditFifo.sv
`timescale 1ns/100ps

module creditFifo #(
	parameter type payload_t = logic,
	parameter int depth = 4
) (
	input logic clock,
	input logic reset,
	input payload_t in,
	input logic push,
	output payload_t out,
	input logic pop,
	output logic empty,
	output logic credit
);

	payload_t entries [depth];
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth+1)-1:0] count;
	logic doPop;

	assign empty = (count == '0);
	assign doPop = pop && !empty;
	assign out = entries[rdPtr]; // head entry comes straight from a register.

	always_ff @(posedge clock) begin
		if (push) begin
			entries[wrPtr] <= in;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= doPop; // one slot handed back to the sender.
			if (push) begin
				wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
			end
			case ({push, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/threadMem.sv
`timescale 1ns/100ps

module threadMem (
	input logic clock,
	input logic reset,
	input mpuPkg::progReq_t progWr,
	input logic [mpuPkg::threadIdWidth-1:0] queryId,
	input logic query,
	output logic hasProg,
	output logic [mpuPkg::lengthWidth-1:0] queryLength,
	output logic queryValid
);
	import mpuPkg::*;

	word_t progStore [numThreads * progDepth];
	logic [lengthWidth-1:0] lengths [numThreads];
	logic [lengthWidth-1:0] writeLength;

	assign writeLength = {1'b0, progWr.index} + 1'b1; // words up to and including this one.

	always_ff @(posedge clock) begin
		if (progWr.write) begin
			progStore[{progWr.threadId, progWr.index}] <= progWr.data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numThreads; i++) begin
				lengths[i] <= '0;
			end
		end else if (progWr.write) begin
			if (progWr.index == '0)
				lengths[progWr.threadId] <= writeLength; // a new program starts over.
			else if (writeLength > lengths[progWr.threadId])
				lengths[progWr.threadId] <= writeLength;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			queryValid <= 1'b0;
		end else begin
			queryValid <= query;
		end
	end

	always_ff @(posedge clock) begin
		if (query) begin
			hasProg <= (lengths[queryId] != '0);
			queryLength <= lengths[queryId];
		end
	end

endmodule

//--- design/dataMem.sv
`timescale 1ns/100ps

module dataMem (
	input logic clock,
	input mpuPkg::dataReq_t req,
	output mpuPkg::word_t rdata,
	output logic rvalid
);
	import mpuPkg::*;

	word_t mem [dataDepth];
	logic readReq;

	assign readReq = req.valid && !req.write;

	always_ff @(posedge clock) begin
		if (req.valid && req.write) begin
			mem[req.addr] <= req.data;
		end
	end

	// read data shows up on the cycle after the address.
	always_ff @(posedge clock) begin
		rvalid <= readReq;
		if (readReq) begin
			rdata <= mem[req.addr];
		end
	end

endmodule

//--- design/hostCmdIf.sv
`timescale 1ns/100ps

module hostCmdIf (
	input logic clock,
	input logic reset,
	input mpuPkg::hostWord_t cmdWord,
	output logic cmdPop,
	output mpuPkg::progReq_t progWr,
	output logic [mpuPkg::threadIdWidth-1:0] queryId,
	output logic query,
	input logic hasProg,
	input logic [mpuPkg::lengthWidth-1:0] queryLength,
	input logic queryValid,
	output mpuPkg::dataReq_t dataReq,
	input mpuPkg::word_t rdata,
	input logic rvalid,
	output mpuPkg::hostWord_t readOut,
	input logic readCredits,
	output mpuPkg::dispatch_t dispatchOut,
	input logic dispatchFree,
	input logic commit,
	output logic [mpuPkg::numLanes-1:0] laneMask,
	output mpuPkg::status_t status
);
	import mpuPkg::*;

	typedef enum logic [3:0] {
		sIdle, sLanes, sProgId, sProgLen, sProgData, sCount, sStride,
		sBase, sStoreData, sLoadData, sRunId, sQuery, sDispatch, sStop
	} state_t;

	state_t state;
	state_t nextCmd;
	word_t word;
	word_t remaining;
	logic [threadIdWidth-1:0] threadId;
	logic [lengthWidth-1:0] runLength;
	logic [progIdxWidth-1:0] progIdx;
	logic [dataAddrWidth-1:0] stride;
	logic [dataAddrWidth-1:0] addr;
	logic loadCmd;
	logic takesWord;
	logic take;
	logic lastWord;
	logic acceptCmd;
	logic storeWrite;
	logic loadIssue;
	logic loadDone;
	logic noProg;
	logic dispatchNow;
	logic setReady;
	logic ready;
	logic running;
	logic stopped;
	logic noThread;

	function automatic state_t decodeCmd(input word_t cmd);
		state_t next;
		if (cmd[cmdRun])
			next = sRunId;
		else if (cmd[cmdStoreProg])
			next = sProgId;
		else if (cmd[cmdStoreData] || cmd[cmdLoadData])
			next = sCount;
		else if (cmd[cmdStop])
			next = sStop;
		else if (cmd[cmdSetLanes])
			next = sLanes;
		else
			next = sIdle; // no known bit, the word is dropped.
		return next;
	endfunction

	always_comb begin
		case (state)
			sLoadData, sQuery, sDispatch: takesWord = 1'b0;
			default: takesWord = 1'b1;
		endcase
	end

	assign word = cmdWord.data;
	assign nextCmd = decodeCmd(word);
	assign cmdPop = cmdWord.valid && takesWord;
	assign take = cmdPop;
	assign lastWord = (remaining == word_t'(1));

	assign acceptCmd = take && (((state == sIdle) && (nextCmd != sIdle)) ||
		((state == sStop) && word[cmdRun]));
	assign storeWrite = (state == sStoreData) && take;
	// one read in flight at a time, so the credit count is current when the next issues.
	assign loadIssue = (state == sLoadData) && (remaining != '0) && readCredits && !rvalid;
	assign loadDone = (state == sLoadData) && rvalid && (remaining == '0);
	assign noProg = (state == sQuery) && queryValid && !hasProg;
	assign dispatchNow = (state == sDispatch) && dispatchFree;

	assign setReady = ((state == sLanes) && take) ||
		((state == sProgLen) && take && (word == '0)) ||
		((state == sProgData) && take && lastWord) ||
		((state == sBase) && take && (remaining == '0)) ||
		(storeWrite && lastWord) || loadDone || noProg || dispatchNow;

	assign progWr = '{write: (state == sProgData) && take, threadId: threadId,
		index: progIdx, data: word};
	assign query = (state == sRunId) && take;
	assign queryId = word[threadIdWidth-1:0];
	assign dataReq = '{valid: storeWrite || loadIssue, write: storeWrite, addr: addr, data: word};
	assign readOut = '{valid: (state == sLoadData) && rvalid, data: rdata};
	assign dispatchOut = '{valid: dispatchNow, threadId: threadId, length: runLength,
		laneMask: laneMask};
	assign status = '{noThread: noThread, stopped: stopped, running: running, ready: ready};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= sIdle;
		end else begin
			case (state)
				sIdle: if (take) state <= nextCmd;
				sLanes: if (take) state <= sIdle;
				sProgId: if (take) state <= sProgLen;
				sProgLen: if (take) state <= (word == '0) ? sIdle : sProgData;
				sProgData: if (take && lastWord) state <= sIdle;
				sCount: if (take) state <= sStride;
				sStride: if (take) state <= sBase;
				sBase: begin
					if (take && (remaining == '0))
						state <= sIdle;
					else if (take)
						state <= loadCmd ? sLoadData : sStoreData;
				end
				sStoreData: if (take && lastWord) state <= sIdle;
				sLoadData: if (loadDone) state <= sIdle;
				sRunId: if (take) state <= sQuery;
				sQuery: if (queryValid) state <= hasProg ? sDispatch : sIdle;
				sDispatch: if (dispatchFree) state <= sIdle;
				sStop: if (take && word[cmdRun]) state <= sRunId; // other words are thrown away.
				default: state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == sIdle) && take) loadCmd <= !word[cmdStoreData];
		if ((state == sProgId || state == sRunId) && take) threadId <= word[threadIdWidth-1:0];
		if ((state == sProgLen || state == sCount) && take) remaining <= word;
		if ((state == sProgLen) && take) progIdx <= '0;
		if ((state == sStride) && take) stride <= word[dataAddrWidth-1:0];
		if ((state == sBase) && take) addr <= word[dataAddrWidth-1:0];
		if (progWr.write) begin
			remaining <= remaining - 1'b1;
			progIdx <= progIdx + 1'b1;
		end
		if (storeWrite || loadIssue) begin
			remaining <= remaining - 1'b1;
			addr <= addr + stride; // wraps around the data memory.
		end
		if ((state == sQuery) && queryValid) runLength <= queryLength;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ready <= 1'b0;
			running <= 1'b0;
			stopped <= 1'b0;
			noThread <= 1'b0;
			laneMask <= '0;
		end else begin
			if (acceptCmd)
				ready <= 1'b0;
			else if (setReady)
				ready <= 1'b1;
			if (commit)
				running <= 1'b0; // lanes hand back the dispatch credit.
			else if (dispatchNow)
				running <= 1'b1;
			if ((state == sStop) && take && word[cmdRun])
				stopped <= 1'b0;
			else if ((state == sIdle) && take && (nextCmd == sStop))
				stopped <= 1'b1;
			if (take && (state == sIdle || state == sStop))
				noThread <= 1'b0;
			else if (noProg)
				noThread <= 1'b1;
			if ((state == sLanes) && take)
				laneMask <= word[numLanes-1:0];
		end
	end

endmodule

//--- design/mpuTop.sv
`timescale 1ns/100ps

module mpuTop (
	input logic clock,
	input logic reset,
	input mpuPkg::hostWord_t hostIn,
	output logic hostCredit,
	output mpuPkg::hostWord_t readOut,
	input logic readCredit,
	output mpuPkg::dispatch_t dispatchOut,
	input logic commit,
	output logic [mpuPkg::numLanes-1:0] laneMask,
	output mpuPkg::status_t status
);
	import mpuPkg::*;

	hostWord_t fifoHead;
	hostWord_t cmdWord;
	logic fifoEmpty;
	logic cmdPop;
	progReq_t progWr;
	logic [threadIdWidth-1:0] queryId;
	logic query;
	logic hasProg;
	logic [lengthWidth-1:0] queryLength;
	logic queryValid;
	dataReq_t dataReq;
	word_t rdata;
	logic rvalid;
	logic [readCreditWidth-1:0] readCount;
	logic dispatchCredit;

	creditFifo #(.payload_t(hostWord_t), .depth(hostFifoDepth)) hostFifo (
		.clock(clock), .reset(reset), .in(hostIn), .push(hostIn.valid),
		.out(fifoHead), .pop(cmdPop), .empty(fifoEmpty), .credit(hostCredit)
	);

	assign cmdWord = '{valid: fifoHead.valid && !fifoEmpty, data: fifoHead.data};

	hostCmdIf cmdIf (
		.clock(clock), .reset(reset), .cmdWord(cmdWord), .cmdPop(cmdPop),
		.progWr(progWr), .queryId(queryId), .query(query), .hasProg(hasProg),
		.queryLength(queryLength), .queryValid(queryValid),
		.dataReq(dataReq), .rdata(rdata), .rvalid(rvalid),
		.readOut(readOut), .readCredits(readCount != '0),
		.dispatchOut(dispatchOut), .dispatchFree(dispatchCredit), .commit(commit),
		.laneMask(laneMask), .status(status)
	);

	threadMem progMem (
		.clock(clock), .reset(reset), .progWr(progWr), .queryId(queryId), .query(query),
		.hasProg(hasProg), .queryLength(queryLength), .queryValid(queryValid)
	);

	dataMem dataStore (.clock(clock), .req(dataReq), .rdata(rdata), .rvalid(rvalid));

	always_ff @(posedge clock) begin
		if (reset) begin
			readCount <= '0;
		end else begin
			case ({readCredit, readOut.valid})
				2'b10: readCount <= readCount + 1'b1;
				2'b01: readCount <= readCount - 1'b1; // each returned word spends a slot.
				default: readCount <= readCount;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			dispatchCredit <= 1'b1; // the lanes can take one record.
		else if (dispatchOut.valid)
			dispatchCredit <= 1'b0;
		else if (commit)
			dispatchCredit <= 1'b1;
	end

endmodule

//--- sim/hostCmdIf_props.sv
`timescale 1ns/100ps

module hostCmdIfProps (
	input logic clock,
	input logic reset,
	input mpuPkg::dispatch_t dispatchOut,
	input logic dispatchFree,
	input mpuPkg::hostWord_t readOut,
	input logic readCredits,
	input mpuPkg::status_t status
);

	dispatchUsesCredit: assert property (@(posedge clock) disable iff (reset)
		dispatchOut.valid |=> !dispatchFree) // the lanes hold a single slot.
		else $error("dispatch credit still free in the cycle after a record was sent");

	readHasCredit: assert property (@(posedge clock) disable iff (reset)
		readOut.valid |-> readCredits)
		else $error("readback word sent while the host granted no slot");

	flagsLowAfterReset: assert property (@(posedge clock)
		reset |=> !status.ready && !status.running)
		else $error("ready or running is set in the cycle after reset");

endmodule

bind hostCmdIf hostCmdIfProps props (.*);

//--- sim/mpuTb.sv
`timescale 1ns/100ps

module mpuTb;
	import mpuPkg::*;

	localparam int maxEntries = 256;
	localparam int cyclesPerLine = 200;
	localparam int recordWidth = threadIdWidth + lengthWidth + numLanes;

	logic clock;
	logic reset;
	hostWord_t hostIn;
	logic hostCredit;
	hostWord_t readOut;
	logic readCredit = 1'b0;
	dispatch_t dispatchOut;
	logic commit = 1'b0;
	logic [numLanes-1:0] laneMask;
	status_t status;

	logic [31:0] patterns [maxEntries];
	word_t readQueue [$];
	logic [recordWidth-1:0] dispatchQueue [$];
	int numLines = 0;
	int wordsSent = 0;
	int creditsBack = 0;
	int readGrants = 0;
	int readsSeen = 0;
	bit lanesBusy = 1'b0;
	bit loaded = 1'b0;

	mpuTop dut (.*);

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at %0t ns", $time);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, want);
			failRun("a checked value differs from the pattern file");
		end
	endtask

	task automatic sendWord(input word_t value);
		while (wordsSent - creditsBack >= hostFifoDepth)
			@(negedge clock); // hold until the port hands a slot back.
		hostIn = '{valid: 1'b1, data: value};
		wordsSent++;
		@(negedge clock);
		hostIn = '{valid: 1'b0, data: '0};
	endtask

	task automatic waitDrained(input bit needReady);
		while (wordsSent != creditsBack || (needReady && !status.ready))
			@(negedge clock);
	endtask

	task automatic expectReadback(input word_t value);
		while (readQueue.size() == 0)
			@(negedge clock);
		checkValue("readOut.data", readQueue.pop_front(), value);
	endtask

	task automatic expectDispatch(input logic [31:0] value);
		while (dispatchQueue.size() == 0 || lanesBusy)
			@(negedge clock); // the commit has to be back first.
		checkValue("dispatchOut", dispatchQueue.pop_front(), value);
		checkValue("laneMask", laneMask, value[numLanes-1:0]);
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// credits from the port, readback words and random read grants.
	always @(negedge clock) begin
		if (!reset) begin
			if (hostCredit) begin
				if (creditsBack >= wordsSent)
					failRun("the port returned a host credit with no word outstanding");
				creditsBack++;
			end
			if (readOut.valid) begin
				readQueue.push_back(readOut.data);
				readsSeen++;
			end
			readCredit = (readGrants - readsSeen < 4) && ($urandom % 3 == 0);
			if (readCredit)
				readGrants++;
		end
	end

	// the lanes take each record and commit it 1 to 5 cycles later.
	always @(negedge clock) begin
		int delay;
		if (!reset && dispatchOut.valid) begin
			dispatchQueue.push_back({dispatchOut.threadId, dispatchOut.length, dispatchOut.laneMask});
			lanesBusy = 1'b1;
			delay = $urandom_range(1, 5);
			@(negedge clock);
			checkValue("status.running", status.running, 1);
			repeat (delay - 1) @(negedge clock);
			commit = 1'b1;
			@(negedge clock);
			commit = 1'b0;
			checkValue("status.running", status.running, 0);
			lanesBusy = 1'b0;
		end
	end

	initial begin
		wait (loaded);
		repeat (numLines * cyclesPerLine) @(posedge clock);
		failRun("timeout: the DUT did not finish the pattern file in time");
	end

	initial begin
		logic [31:0] op;
		logic [31:0] value;
		void'($urandom(32'h4e19_3bf1));
		reset = 1'b1;
		hostIn = '0;
		$readmemh("sim/mpu_patterns.txt", patterns);
		while (numLines < maxEntries / 2 && patterns[2 * numLines] !== 32'h0)
			numLines++;
		loaded = 1'b1;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < numLines; i++) begin
			op = patterns[2 * i];
			value = patterns[2 * i + 1];
			case (op)
				1: sendWord(value);
				2: expectReadback(value);
				3: expectDispatch(value);
				4: begin
					waitDrained(1'b0);
					checkValue("status", status, value);
				end
				5: waitDrained(1'b1);
				default: failRun($sformatf("unknown opcode %0h on pattern line %0d", op, i));
			endcase
		end
		@(negedge clock);
		checkValue("unclaimed readback words", readQueue.size(), 0);
		checkValue("unclaimed dispatch records", dispatchQueue.size(), 0);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- compile.f
design/mpuPkg.sv
design/creditFifo.sv
design/threadMem.sv
design/dataMem.sv
design/hostCmdIf.sv
design/mpuTop.sv
sim/hostCmdIf_props.sv
sim/mpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mpuTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILELIST BUILD_DIR VERILATOR_FLAGS PASS_TEXT"

$(BINARY): $(FILELIST) $(wildcard design/*.sv sim/*.sv)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BINARY)
	@out="$$(./$(BINARY) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/mpu_patterns.txt
// columns: opcode, value. 1 send host word, 2 expect readback word, 3 expect dispatch
// {threadId, length, laneMask}, 4 expect status {noThread, stopped, running, ready}, 5 wait ready, 0 end
4 00000000 // status after reset
1 00000004 // store data, count 5, stride 3, base 250
1 00000005
1 00000003
1 000000FA
1 11110000
1 22220001
1 33330002
1 44440003
1 55550004
1 00000008 // load data with the same count, stride and base
1 00000005
1 00000003
1 000000FA
2 11110000
2 22220001
2 33330002
2 44440003
2 55550004
1 00000020 // set lanes
1 000000A5
1 00000002 // store program, thread 2, length 4
1 00000002
1 00000004
1 0000C001
1 0000C002
1 0000C003
1 0000C004
1 00000001 // run thread 2
1 00000002
3 000084A5
1 00000001 // run thread 7, which holds no program
1 00000007
5 00000000
4 00000009
1 00000040 // unknown command word
4 00000001
1 00000020 // new lane mask
1 0000003C
1 00000010 // stop
4 00000004
1 00000008 // load data while stopped, no word has bit 0 set
1 00000002
1 00000004
1 00000010
1 00000001 // run thread 2 again
1 00000002
3 0000843C
5 00000000
4 00000001
0 00000000 // end of patterns
